// ==== gpu_csr.f ====
source/core_types_pkg.sv
source/csr_map_pkg.sv
source/csr_ifs.sv
source/perf_counters.sv
source/csr_unit.sv
source/csr_data.sv
source/gpu_csr_top.sv
tests/tb_gpu_csr.sv

// ==== Makefile ====
TOP = tb_gpu_csr

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f gpu_csr.f

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f gpu_csr.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== tests/tb_gpu_csr.sv ====
`timescale 1ns/1ps

module tb_gpu_csr;
    import core_types_pkg::*;
    import csr_map_pkg::*;

    localparam int NUM_WARPS = 4;
    localparam int CORE_ID   = 2;
    localparam int WID_BITS  = 2;
    localparam int CMT_BITS  = $clog2(NUM_THREADS + 1);
    localparam int TIMEOUT   = 20;  // Cycles allowed for any response

    localparam csr_addr_t MREG [9] = '{CSR_SATP, CSR_MSTATUS, CSR_MEDELEG, CSR_MIDELEG,
        CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0};
    localparam csr_addr_t FPV [3] = '{CSR_FFLAGS, CSR_FRM, CSR_FCSR};
    // Cycle, instret, then the ibuf, scoreboard, lsu and fpu stall counters
    localparam csr_addr_t CNT_LO [6] = '{CSR_CYCLE, CSR_INSTRET, CSR_MPM_IBUF_ST,
        CSR_MPM_SCRB_ST, CSR_MPM_LSU_ST, CSR_MPM_FPU_ST};
    localparam csr_addr_t CNT_HI [6] = '{CSR_CYCLE_H, CSR_INSTRET_H, CSR_MPM_IBUF_ST_H,
        CSR_MPM_SCRB_ST_H, CSR_MPM_LSU_ST_H, CSR_MPM_FPU_ST_H};
    localparam csr_op_t OPS [3] = '{CSR_RW, CSR_RS, CSR_RC};

    logic                     clk, reset, req_valid, rsp_valid;
    logic [1:0]               req_op;
    logic [CSR_ADDR_BITS-1:0] req_addr;
    logic [WID_BITS-1:0]      req_wid, rsp_wid, fpu_fflags_wid, fpu_frm_wid;
    logic [CSR_WIDTH-1:0]     req_rs1_data, rsp_data;
    logic                     busy, commit_valid, fpu_fflags_valid;
    logic [CMT_BITS-1:0]      commit_size;
    logic [FFG_BITS-1:0]      fpu_fflags;
    logic [FRM_BITS-1:0]      fpu_frm;
    logic                     ibuf_stall, scb_stall, lsu_stall, fpu_stall;

    logic [31:0] rand_state;
    logic [31:0] mreg_model [9] = '{default: '0};
    logic [7:0]  fcsr_model [NUM_WARPS] = '{default: '0};  // {frm, fflags}
    logic [43:0] cnt_model [6] = '{default: '0};

    gpu_csr_top #(.CORE_ID(CORE_ID), .NUM_WARPS(NUM_WARPS)) DUT (.*);

    always #10 clk = ~clk;

    // ==========================================================
    // Models and request helpers
    // ==========================================================

    function automatic logic [31:0] next_rand();
        rand_state ^= rand_state << 13;
        rand_state ^= rand_state >> 17;
        rand_state ^= rand_state << 5;
        return rand_state;
    endfunction

    function automatic logic [31:0] op_result(csr_op_t op, logic [31:0] old, logic [31:0] rs1);
        case (op)
            CSR_RW:  return rs1;
            CSR_RS:  return old | rs1;
            default: return old & ~rs1;
        endcase
    endfunction

    // View 0 is fflags, 1 is frm and 2 is the whole fcsr
    function automatic logic [31:0] fcsr_view(int v, int w);
        case (v)
            0:       return 32'(fcsr_model[w][4:0]);
            1:       return 32'(fcsr_model[w][7:5]);
            default: return 32'(fcsr_model[w]);
        endcase
    endfunction

    task automatic update_fcsr(int v, int w, logic [31:0] value);
        case (v)
            0:       fcsr_model[w][4:0] = value[4:0];
            1:       fcsr_model[w][7:5] = value[2:0];
            default: fcsr_model[w] = value[7:0];
        endcase
    endtask

    task automatic check_value(string what, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Some tests failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Starts on a falling edge and returns on the edge where the response is checked
    task automatic request(csr_op_t op, csr_addr_t addr, int w, logic [31:0] rs1,
                           logic [31:0] expected, string what);
        int waited;
        req_valid    = 1'b1;
        req_op       = op;
        req_addr     = addr;
        req_wid      = WID_BITS'(w);
        req_rs1_data = rs1;
        @(negedge clk);
        req_valid = 1'b0;  // A following request raises it again at this same edge
        waited    = 1;
        while (!rsp_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp_valid) begin
            $display("No response to the %s request within %0d cycles", what, TIMEOUT);
            $display("Some tests failed");
            $fatal(1, "Response timeout");
        end
        check_value({what, " delay"}, 32'(waited), 32'd1);
        check_value({what, " warp"}, 32'(rsp_wid), 32'(w));
        check_value(what, rsp_data, expected);
    endtask

    task automatic read_csr(csr_addr_t addr, int w, logic [31:0] expected, string what);
        request(CSR_RS, addr, w, 32'd0, expected, what);  // A zero set mask only reads
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================

    task automatic reset_values();
        check_value("rsp_valid after reset", 32'(rsp_valid), 32'd0);
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int v = 0; v < 3; v++) begin
                read_csr(FPV[v], w, 32'd0, "fp state after reset");
            end
            read_csr(CSR_WTID, w, 32'(w), "WTID");
            read_csr(CSR_LTID, w, 32'(w), "LTID");
            read_csr(CSR_LWID, w, 32'(w), "LWID");
            read_csr(CSR_GTID, w, 32'(CORE_ID * NUM_WARPS + w), "GTID");
            read_csr(CSR_GWID, w, 32'(CORE_ID * NUM_WARPS + w), "GWID");
            read_csr(CSR_GCID, w, 32'(CORE_ID), "GCID");
            read_csr(CSR_NT, w, 32'(NUM_THREADS), "NT");
            read_csr(CSR_NW, w, 32'(NUM_WARPS), "NW");
            read_csr(CSR_NC, w, 32'(NUM_CORES * NUM_CLUSTERS), "NC");
        end
        read_csr(CSR_MVENDORID, 0, VENDOR_ID, "mvendorid");
        read_csr(CSR_MARCHID, 0, ARCHITECTURE_ID, "marchid");
        read_csr(CSR_MIMPID, 0, IMPLEMENTATION_ID, "mimpid");
        request(CSR_RW, 12'h7C0, 1, 32'hFFFF_FFFF, 32'd0, "unmapped write");
        request(CSR_RW, CSR_MISA, 1, 32'h0, ISA_CODE, "misa write");
        read_csr(12'h7C0, 1, 32'd0, "unmapped read");
        read_csr(CSR_MISA, 1, ISA_CODE, "misa after write");
        // A lone request gives a single-cycle response
        @(negedge clk);
        check_value("rsp_valid one cycle after a response", 32'(rsp_valid), 32'd0);
        for (int i = 0; i < 9; i++) begin
            read_csr(MREG[i], 0, 32'd0, "machine register after reset");
        end
    endtask

    task automatic machine_register_ops();
        int          idx;
        csr_op_t     op;
        logic [31:0] rs1;
        logic [31:0] old;
        for (int n = 0; n < 300; n++) begin
            idx = int'(next_rand() % 9);
            op  = OPS[int'(next_rand() % 3)];
            rs1 = next_rand();
            if (rs1[1:0] == 2'b00) begin
                rs1 = '0;  // A quarter of the masks are zero and must leave the register alone
            end
            old             = mreg_model[idx];
            mreg_model[idx] = op_result(op, old, rs1);
            request(op, MREG[idx], int'(next_rand() % NUM_WARPS), rs1, old, "machine register");
        end
        for (int i = 0; i < 9; i++) begin
            read_csr(MREG[i], 3, mreg_model[i], "machine register readback");
        end
    endtask

    task automatic float_state();
        int          v;
        int          w;
        csr_op_t     op;
        logic [31:0] rs1;
        logic [31:0] old;
        for (int n = 0; n < 200; n++) begin
            v   = int'(next_rand() % 3);
            w   = int'(next_rand() % NUM_WARPS);
            op  = OPS[int'(next_rand() % 3)];
            rs1 = next_rand();
            old = fcsr_view(v, w);
            update_fcsr(v, w, op_result(op, old, rs1));
            request(op, FPV[v], w, rs1, old, "fp CSR");
        end
        for (int k = 0; k < NUM_WARPS; k++) begin
            for (int j = 0; j < 3; j++) begin
                read_csr(FPV[j], k, fcsr_view(j, k), "fp view readback");
            end
            fpu_frm_wid = WID_BITS'(k);
            @(posedge clk);
            check_value("fpu_frm", 32'(fpu_frm), 32'(fcsr_model[k][7:5]));
            @(negedge clk);
        end
    endtask

    task automatic fflags_accumulation();
        int          w;
        logic [4:0]  flags;
        logic [31:0] rs1;
        for (int n = 0; n < 12; n++) begin
            w                  = int'(next_rand() % NUM_WARPS);
            flags              = 5'(next_rand());
            fpu_fflags_valid   = 1'b1;
            fpu_fflags_wid     = WID_BITS'(w);
            fpu_fflags         = flags;
            fcsr_model[w][4:0] = fcsr_model[w][4:0] | flags;
            @(negedge clk);
            fpu_fflags_valid = 1'b0;
        end
        for (int k = 0; k < NUM_WARPS; k++) begin
            read_csr(CSR_FFLAGS, k, fcsr_view(0, k), "accumulated fflags");
            // FPU flags and a CSR write land on the same warp at one edge
            rs1              = next_rand();
            fpu_fflags_valid = 1'b1;
            fpu_fflags_wid   = WID_BITS'(k);
            fpu_fflags       = ~rs1[4:0];
            request(CSR_RW, CSR_FFLAGS, k, rs1, fcsr_view(0, k), "fflags collision");
            fpu_fflags_valid   = 1'b0;
            fcsr_model[k][4:0] = rs1[4:0];
            read_csr(CSR_FFLAGS, k, fcsr_view(0, k), "fflags after collision");
        end
    endtask

    task automatic counter_totals();
        int          len [6];
        logic [31:0] r;
        len[0] = 30 + int'(next_rand() % 40);  // Busy cycles
        len[1] = 0;
        for (int i = 2; i < 6; i++) begin
            len[i] = 5 + int'(next_rand() % 60);
        end
        for (int c = 0; c < 80; c++) begin
            r            = next_rand();
            busy         = (c < len[0]);
            commit_valid = r[0];
            commit_size  = CMT_BITS'(r[31:8] % (NUM_THREADS + 1));
            ibuf_stall   = (c < len[2]);
            scb_stall    = (c < len[3]);
            lsu_stall    = (c < len[4]);
            fpu_stall    = (c < len[5]);
            if (r[0]) begin
                cnt_model[1] += 44'(commit_size);
            end
            @(negedge clk);
        end
        {busy, commit_valid, ibuf_stall, scb_stall, lsu_stall, fpu_stall} = '0;
        for (int i = 0; i < 6; i++) begin
            if (i != 1) begin
                cnt_model[i] = 44'(len[i]);
            end
            read_csr(CNT_LO[i], 0, cnt_model[i][31:0], "counter low word");
            read_csr(CNT_HI[i], 0, 32'(cnt_model[i][43:32]), "counter high word");
        end
    endtask

    initial begin
        rand_state   = 32'he82d;
        clk          = 1'b0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_op       = 2'b00;
        req_addr     = '0;
        req_wid      = '0;
        req_rs1_data = '0;
        commit_size  = '0;
        fpu_fflags   = '0;
        {busy, commit_valid, fpu_fflags_valid, fpu_fflags_wid, fpu_frm_wid} = '0;
        {ibuf_stall, scb_stall, lsu_stall, fpu_stall} = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        reset_values();
        machine_register_ops();
        float_state();
        fflags_accumulation();
        counter_totals();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== source/gpu_csr_top.sv ====
`timescale 1ns/1ps

module gpu_csr_top #(
    parameter  int CORE_ID   = 0,
    parameter  int NUM_WARPS = 4,
    localparam int WID_BITS  = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1,
    localparam int CMT_BITS  = $clog2(core_types_pkg::NUM_THREADS + 1)
) (
    input  logic                                     clk,
    input  logic                                     reset,

    input  logic                                     req_valid,
    input  logic [1:0]                               req_op,
    input  logic [core_types_pkg::CSR_ADDR_BITS-1:0] req_addr,
    input  logic [WID_BITS-1:0]                      req_wid,
    input  logic [core_types_pkg::CSR_WIDTH-1:0]     req_rs1_data,
    output logic                                     rsp_valid,
    output logic [WID_BITS-1:0]                      rsp_wid,
    output logic [core_types_pkg::CSR_WIDTH-1:0]     rsp_data,

    input  logic                                     busy,
    input  logic                                     commit_valid,
    input  logic [CMT_BITS-1:0]                      commit_size,

    input  logic                                     fpu_fflags_valid,
    input  logic [WID_BITS-1:0]                      fpu_fflags_wid,
    input  logic [core_types_pkg::FFG_BITS-1:0]      fpu_fflags,
    input  logic [WID_BITS-1:0]                      fpu_frm_wid,
    output logic [core_types_pkg::FRM_BITS-1:0]      fpu_frm,

    input  logic                                     ibuf_stall,
    input  logic                                     scb_stall,
    input  logic                                     lsu_stall,
    input  logic                                     fpu_stall
);
    import core_types_pkg::*;

    csr_access_if #(.NUM_WARPS(NUM_WARPS)) access_if ();
    fpu_csr_if #(.NUM_WARPS(NUM_WARPS))    fpu_if ();
    perf_pipeline_if                       perf_if ();

    // FPU side of the flag and rounding-mode port
    assign fpu_if.write_enable = fpu_fflags_valid;
    assign fpu_if.write_wid    = fpu_fflags_wid;
    assign fpu_if.write_fflags = fpu_fflags;
    assign fpu_if.read_wid     = fpu_frm_wid;
    assign fpu_frm             = fpu_if.read_frm;

    csr_unit #(.NUM_WARPS(NUM_WARPS)) u_csr_unit (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_op       (csr_op_t'(req_op)),
        .req_addr     (req_addr),
        .req_wid      (req_wid),
        .req_rs1_data (req_rs1_data),
        .rsp_valid    (rsp_valid),
        .rsp_wid      (rsp_wid),
        .rsp_data     (rsp_data),
        .access       (access_if.master)
    );

    csr_data #(.CORE_ID(CORE_ID), .NUM_WARPS(NUM_WARPS)) u_csr_data (
        .clk          (clk),
        .reset        (reset),
        .busy         (busy),
        .commit_valid (commit_valid),
        .commit_size  (commit_size),
        .access       (access_if.slave),
        .fpu          (fpu_if.slave),
        .perf         (perf_if.sink)
    );

    perf_counters u_perf_counters (
        .clk        (clk),
        .reset      (reset),
        .ibuf_stall (ibuf_stall),
        .scb_stall  (scb_stall),
        .lsu_stall  (lsu_stall),
        .fpu_stall  (fpu_stall),
        .perf       (perf_if.source)
    );

endmodule

// ==== source/csr_data.sv ====
`timescale 1ns/1ps

module csr_data #(
    parameter  int CORE_ID   = 0,
    parameter  int NUM_WARPS = 4,
    localparam int CMT_BITS  = $clog2(core_types_pkg::NUM_THREADS + 1)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                busy,
    input  logic                commit_valid,
    input  logic [CMT_BITS-1:0] commit_size,
    csr_access_if.slave         access,
    fpu_csr_if.slave            fpu,
    perf_pipeline_if.sink       perf
);
    import core_types_pkg::*;
    import csr_map_pkg::*;

    localparam int FCSR_BITS = FRM_BITS + FFG_BITS;

    logic [CSR_WIDTH-1:0] csr_satp;
    logic [CSR_WIDTH-1:0] csr_mstatus;
    logic [CSR_WIDTH-1:0] csr_medeleg;
    logic [CSR_WIDTH-1:0] csr_mideleg;
    logic [CSR_WIDTH-1:0] csr_mie;
    logic [CSR_WIDTH-1:0] csr_mtvec;
    logic [CSR_WIDTH-1:0] csr_mepc;
    logic [CSR_WIDTH-1:0] csr_pmpcfg0;
    logic [CSR_WIDTH-1:0] csr_pmpaddr0;

    logic [NUM_WARPS-1:0][FCSR_BITS-1:0] fcsr;  // {frm, fflags} per warp

    logic [PERF_CNT_BITS-1:0] csr_cycle;
    logic [PERF_CNT_BITS-1:0] csr_instret;
    logic [CSR_WIDTH-1:0]     read_data_r;

    // ==========================================================
    // Register writes
    // ==========================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_satp     <= '0;
            csr_mstatus  <= '0;
            csr_medeleg  <= '0;
            csr_mideleg  <= '0;
            csr_mie      <= '0;
            csr_mtvec    <= '0;
            csr_mepc     <= '0;
            csr_pmpcfg0  <= '0;
            csr_pmpaddr0 <= '0;
            fcsr         <= '0;
        end else begin
            if (fpu.write_enable) begin
                fcsr[fpu.write_wid][FFG_BITS-1:0] <=
                    fcsr[fpu.write_wid][FFG_BITS-1:0] | fpu.write_fflags;
            end
            // Comes after the FPU update so a CSR write to the same flags wins
            if (access.write_enable) begin
                case (access.write_addr)
                    CSR_FFLAGS:   fcsr[access.write_wid][FFG_BITS-1:0] <=
                                      access.write_data[FFG_BITS-1:0];
                    CSR_FRM:      fcsr[access.write_wid][FCSR_BITS-1:FFG_BITS] <=
                                      access.write_data[FRM_BITS-1:0];
                    CSR_FCSR:     fcsr[access.write_wid] <= access.write_data[FCSR_BITS-1:0];
                    CSR_SATP:     csr_satp     <= access.write_data;
                    CSR_MSTATUS:  csr_mstatus  <= access.write_data;
                    CSR_MEDELEG:  csr_medeleg  <= access.write_data;
                    CSR_MIDELEG:  csr_mideleg  <= access.write_data;
                    CSR_MIE:      csr_mie      <= access.write_data;
                    CSR_MTVEC:    csr_mtvec    <= access.write_data;
                    CSR_MEPC:     csr_mepc     <= access.write_data;
                    CSR_PMPCFG0:  csr_pmpcfg0  <= access.write_data;
                    CSR_PMPADDR0: csr_pmpaddr0 <= access.write_data;
                    default: ;  // Read-only or unknown
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_cycle   <= '0;
            csr_instret <= '0;
        end else begin
            if (busy) csr_cycle <= csr_cycle + PERF_CNT_BITS'(1);
            if (commit_valid) csr_instret <= csr_instret + PERF_CNT_BITS'(commit_size);
        end
    end

    // ==========================================================
    // Read decode
    // ==========================================================

    always_comb begin
        read_data_r = '0;
        case (access.read_addr)
            CSR_FFLAGS:        read_data_r = 32'(fcsr[access.read_wid][FFG_BITS-1:0]);
            CSR_FRM:           read_data_r = 32'(fcsr[access.read_wid][FCSR_BITS-1:FFG_BITS]);
            CSR_FCSR:          read_data_r = 32'(fcsr[access.read_wid]);
            CSR_WTID,
            CSR_LTID,
            CSR_LWID:          read_data_r = 32'(access.read_wid);
            CSR_GTID,
            CSR_GWID:          read_data_r = 32'(CORE_ID * NUM_WARPS) + 32'(access.read_wid);
            CSR_GCID:          read_data_r = 32'(CORE_ID);
            CSR_NT:            read_data_r = 32'(NUM_THREADS);
            CSR_NW:            read_data_r = 32'(NUM_WARPS);
            CSR_NC:            read_data_r = 32'(NUM_CORES * NUM_CLUSTERS);
            CSR_SATP:          read_data_r = csr_satp;
            CSR_MSTATUS:       read_data_r = csr_mstatus;
            CSR_MISA:          read_data_r = ISA_CODE;
            CSR_MEDELEG:       read_data_r = csr_medeleg;
            CSR_MIDELEG:       read_data_r = csr_mideleg;
            CSR_MIE:           read_data_r = csr_mie;
            CSR_MTVEC:         read_data_r = csr_mtvec;
            CSR_MEPC:          read_data_r = csr_mepc;
            CSR_PMPCFG0:       read_data_r = csr_pmpcfg0;
            CSR_PMPADDR0:      read_data_r = csr_pmpaddr0;
            CSR_CYCLE:         read_data_r = csr_cycle[31:0];
            CSR_CYCLE_H:       read_data_r = 32'(csr_cycle[43:32]);
            CSR_INSTRET:       read_data_r = csr_instret[31:0];
            CSR_INSTRET_H:     read_data_r = 32'(csr_instret[43:32]);
            CSR_MPM_IBUF_ST:   read_data_r = perf.ibuf_stalls[31:0];
            CSR_MPM_IBUF_ST_H: read_data_r = 32'(perf.ibuf_stalls[43:32]);
            CSR_MPM_SCRB_ST:   read_data_r = perf.scb_stalls[31:0];
            CSR_MPM_SCRB_ST_H: read_data_r = 32'(perf.scb_stalls[43:32]);
            CSR_MPM_LSU_ST:    read_data_r = perf.lsu_stalls[31:0];
            CSR_MPM_LSU_ST_H:  read_data_r = 32'(perf.lsu_stalls[43:32]);
            CSR_MPM_FPU_ST:    read_data_r = perf.fpu_stalls[31:0];
            CSR_MPM_FPU_ST_H:  read_data_r = 32'(perf.fpu_stalls[43:32]);
            CSR_MVENDORID:     read_data_r = VENDOR_ID;
            CSR_MARCHID:       read_data_r = ARCHITECTURE_ID;
            CSR_MIMPID:        read_data_r = IMPLEMENTATION_ID;
            default: ;
        endcase
    end

    assign access.read_data = access.read_enable ? read_data_r : '0;  // Quiet bus when idle
    assign fpu.read_frm     = fcsr[fpu.read_wid][FCSR_BITS-1:FFG_BITS];

endmodule

// ==== source/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit #(
    parameter  int NUM_WARPS = 4,
    localparam int WID_BITS  = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    req_valid,
    input  core_types_pkg::csr_op_t                 req_op,
    input  logic [core_types_pkg::CSR_ADDR_BITS-1:0] req_addr,
    input  logic [WID_BITS-1:0]                     req_wid,
    input  logic [core_types_pkg::CSR_WIDTH-1:0]    req_rs1_data,
    output logic                                    rsp_valid,
    output logic [WID_BITS-1:0]                     rsp_wid,
    output logic [core_types_pkg::CSR_WIDTH-1:0]    rsp_data,
    csr_access_if.master                            access
);
    import core_types_pkg::*;

    logic [CSR_WIDTH-1:0] old_value;
    logic [CSR_WIDTH-1:0] new_value;
    logic                 do_write;

    assign old_value = access.read_data;

    // Set and clear with a zero mask leave the register untouched
    always_comb begin
        new_value = old_value;
        do_write  = 1'b0;
        case (req_op)
            CSR_RW: begin
                new_value = req_rs1_data;
                do_write  = 1'b1;
            end
            CSR_RS: begin
                new_value = old_value | req_rs1_data;
                do_write  = (req_rs1_data != '0);
            end
            CSR_RC: begin
                new_value = old_value & ~req_rs1_data;
                do_write  = (req_rs1_data != '0);
            end
            default: ;
        endcase
    end

    assign access.read_enable  = req_valid;
    assign access.read_addr    = req_addr;
    assign access.read_wid     = req_wid;
    assign access.write_enable = req_valid && do_write;
    assign access.write_addr   = req_addr;
    assign access.write_wid    = req_wid;
    assign access.write_data   = new_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp_wid  <= req_wid;
            rsp_data <= old_value;  // Value seen before this request's write
        end
    end

endmodule

// ==== source/perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters (
    input  logic            clk,
    input  logic            reset,
    input  logic            ibuf_stall,
    input  logic            scb_stall,
    input  logic            lsu_stall,
    input  logic            fpu_stall,
    perf_pipeline_if.source perf
);
    import core_types_pkg::*;

    localparam int NUM_CNT = 4;

    logic [NUM_CNT-1:0]       stall;
    logic [PERF_CNT_BITS-1:0] count [NUM_CNT];

    assign stall = {fpu_stall, lsu_stall, scb_stall, ibuf_stall};

    // At 44 bits these do not wrap in any realistic run
    for (genvar i = 0; i < NUM_CNT; i++) begin : g_cnt
        always_ff @(posedge clk) begin
            if (reset) begin
                count[i] <= '0;
            end else if (stall[i]) begin
                count[i] <= count[i] + PERF_CNT_BITS'(1);
            end
        end
    end

    assign perf.ibuf_stalls = count[0];
    assign perf.scb_stalls  = count[1];
    assign perf.lsu_stalls  = count[2];
    assign perf.fpu_stalls  = count[3];

endmodule

// ==== source/csr_ifs.sv ====
`timescale 1ns/1ps

interface csr_access_if #(
    parameter int NUM_WARPS = 4
);
    import core_types_pkg::*;

    localparam int WID_BITS = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    logic                     read_enable;
    logic [CSR_ADDR_BITS-1:0] read_addr;
    logic [WID_BITS-1:0]      read_wid;
    logic [CSR_WIDTH-1:0]     read_data;  // Combinational from the address and warp

    logic                     write_enable;
    logic [CSR_ADDR_BITS-1:0] write_addr;
    logic [WID_BITS-1:0]      write_wid;
    logic [CSR_WIDTH-1:0]     write_data;

    modport master (output read_enable, read_addr, read_wid, input read_data,
                    output write_enable, write_addr, write_wid, write_data);
    modport slave (input read_enable, read_addr, read_wid, output read_data,
                   input write_enable, write_addr, write_wid, write_data);
endinterface

interface fpu_csr_if #(
    parameter int NUM_WARPS = 4
);
    import core_types_pkg::*;

    localparam int WID_BITS = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    logic                write_enable;
    logic [WID_BITS-1:0] write_wid;
    logic [FFG_BITS-1:0] write_fflags;
    logic [WID_BITS-1:0] read_wid;
    logic [FRM_BITS-1:0] read_frm;

    modport master (output write_enable, write_wid, write_fflags, read_wid, input read_frm);
    modport slave (input write_enable, write_wid, write_fflags, read_wid, output read_frm);
endinterface

interface perf_pipeline_if;
    import core_types_pkg::*;

    logic [PERF_CNT_BITS-1:0] ibuf_stalls;
    logic [PERF_CNT_BITS-1:0] scb_stalls;
    logic [PERF_CNT_BITS-1:0] lsu_stalls;
    logic [PERF_CNT_BITS-1:0] fpu_stalls;

    modport source (output ibuf_stalls, scb_stalls, lsu_stalls, fpu_stalls);
    modport sink (input ibuf_stalls, scb_stalls, lsu_stalls, fpu_stalls);
endinterface

// ==== source/csr_map_pkg.sv ====
package csr_map_pkg;

    typedef logic [core_types_pkg::CSR_ADDR_BITS-1:0] csr_addr_t;

    // ==========================================================
    // Standard RISC-V addresses
    // ==========================================================

    localparam csr_addr_t CSR_FFLAGS    = 12'h001;
    localparam csr_addr_t CSR_FRM       = 12'h002;
    localparam csr_addr_t CSR_FCSR      = 12'h003;
    localparam csr_addr_t CSR_SATP      = 12'h180;
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MEDELEG   = 12'h302;
    localparam csr_addr_t CSR_MIDELEG   = 12'h303;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_PMPCFG0   = 12'h3A0;
    localparam csr_addr_t CSR_PMPADDR0  = 12'h3B0;
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_INSTRET   = 12'hC02;
    localparam csr_addr_t CSR_CYCLE_H   = 12'hC80;
    localparam csr_addr_t CSR_INSTRET_H = 12'hC82;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;

    // ==========================================================
    // Vendor range: identity and stall counters
    // ==========================================================

    localparam csr_addr_t CSR_WTID = 12'hCC0;
    localparam csr_addr_t CSR_LTID = 12'hCC1;
    localparam csr_addr_t CSR_LWID = 12'hCC2;
    localparam csr_addr_t CSR_GTID = 12'hCC3;
    localparam csr_addr_t CSR_GWID = 12'hCC4;
    localparam csr_addr_t CSR_GCID = 12'hCC5;
    localparam csr_addr_t CSR_NT   = 12'hFC0;
    localparam csr_addr_t CSR_NW   = 12'hFC1;
    localparam csr_addr_t CSR_NC   = 12'hFC2;

    localparam csr_addr_t CSR_MPM_IBUF_ST   = 12'hB03;
    localparam csr_addr_t CSR_MPM_SCRB_ST   = 12'hB04;
    localparam csr_addr_t CSR_MPM_LSU_ST    = 12'hB05;
    localparam csr_addr_t CSR_MPM_FPU_ST    = 12'hB06;
    localparam csr_addr_t CSR_MPM_IBUF_ST_H = 12'hB83;  // High words sit 0x80 above
    localparam csr_addr_t CSR_MPM_SCRB_ST_H = 12'hB84;
    localparam csr_addr_t CSR_MPM_LSU_ST_H  = 12'hB85;
    localparam csr_addr_t CSR_MPM_FPU_ST_H  = 12'hB86;

    localparam logic [31:0] ISA_CODE          = 32'h4000_1120;  // RV32IMF
    localparam logic [31:0] VENDOR_ID         = 32'h0000_0000;
    localparam logic [31:0] ARCHITECTURE_ID   = 32'h0000_0001;
    localparam logic [31:0] IMPLEMENTATION_ID = 32'h0000_0001;

endpackage

// ==== source/core_types_pkg.sv ====
package core_types_pkg;

    // ==========================================================
    // Datapath widths
    // ==========================================================

    localparam int CSR_ADDR_BITS = 12;
    localparam int CSR_WIDTH     = 32;
    localparam int FFG_BITS      = 5;   // NV, DZ, OF, UF, NX
    localparam int FRM_BITS      = 3;
    localparam int PERF_CNT_BITS = 44;

    // ==========================================================
    // Core configuration
    // ==========================================================

    localparam int NUM_THREADS  = 4;
    localparam int NUM_CORES    = 4;
    localparam int NUM_CLUSTERS = 1;

    // Matches the low two bits of funct3 in the Zicsr encodings
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

endpackage
